//--- verilog/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Width of one instruction word on the instruction port
`define CORE_INSTR_W 16
// Instruction address width, the program space is 256 words
`define CORE_ADDR_W 8
// Accumulator and result width
`define CORE_DATA_W 16
// Number of words the prefetch buffer can hold
`define CORE_BUF_DEPTH 4

// Instruction fields with the opcode on top and the immediate at the bottom
`define CORE_OP_MSB 15
`define CORE_OP_LSB 14
`define CORE_IMM_W 8

`endif

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction opcodes taken from bits 15 to 14
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_NOP  = 2'b00,
    // Accumulator plus zero-extended low byte
    OP_ADDI = 2'b01,
    // Accumulator goes out on the result port
    OP_OUT  = 2'b10,
    OP_WFI  = 2'b11
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RESET      = 2'b00,
    RUN        = 2'b01,
    WAIT_SLEEP = 2'b10,
    SLEEP      = 2'b11
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/instr_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

// Link between fetch, the prefetch buffer and the controller
interface instr_buf_if;

  // Word returned by the instruction port, written into the buffer
  logic                     push_valid;
  logic [`CORE_INSTR_W-1:0] push_data;
  // Fetch has a request in flight, so one slot must stay reserved
  logic                     outstanding;
  // No room for another request
  logic                     full;

  logic                     empty;
  // The head of the buffer is always visible
  logic [`CORE_INSTR_W-1:0] pop_data;
  logic                     pop;

  // Fetch side
  modport producer (
    output push_valid, push_data, outstanding,
    input  full
  );

  // The buffer itself
  modport store (
    input  push_valid, push_data, outstanding, pop,
    output full, empty, pop_data
  );

  // Controller side
  modport consumer (
    output pop,
    input  empty, pop_data
  );

endinterface

`default_nettype wire

//--- verilog/core_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_fetch (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     fetch_en_i,
  input  logic                     halt_i,

  // Instruction port
  output logic                     instr_req_o,
  output logic [`CORE_ADDR_W-1:0]  instr_addr_o,
  input  logic [`CORE_INSTR_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,

  // High while a request waits for its data
  output logic                     busy_o,

  instr_buf_if.producer            buf_o
);

  logic [`CORE_ADDR_W-1:0] addr_q;
  logic                    outstanding_q;
  logic                    req;
  logic                    resp;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Only one request in flight, and none once the controller halts for WFI
  assign req = fetch_en_i && !halt_i && !outstanding_q && !buf_o.full;

  // A returned word only counts if we actually asked for it
  assign resp = instr_rvalid_i && outstanding_q;

  assign instr_req_o  = req;
  assign instr_addr_o = addr_q;
  assign busy_o       = outstanding_q;

  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      addr_q        <= '0;
      outstanding_q <= 1'b0;
    end else begin
      // Set by the request strobe, cleared by the single answer
      if (req) begin
        outstanding_q <= 1'b1;
      end else if (resp) begin
        outstanding_q <= 1'b0;
      end
      // The address moves on when the data is in, so a wake resumes after the last word
      if (resp) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Push into the buffer
  ////////////////////////////////////////////////////////////

  assign buf_o.push_valid  = resp;
  assign buf_o.push_data   = instr_rdata_i;
  assign buf_o.outstanding = outstanding_q;

endmodule

`default_nettype wire

//--- verilog/core_prefetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_prefetch_buffer (
  input  logic       clk_i,
  input  logic       rst_n,

  instr_buf_if.store buf_io
);

  localparam int PTR_W = $clog2(`CORE_BUF_DEPTH);
  localparam int CNT_W = $clog2(`CORE_BUF_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`CORE_BUF_DEPTH - 1);

  logic [`CORE_INSTR_W-1:0] mem_q [`CORE_BUF_DEPTH];
  logic [PTR_W-1:0]         wptr_q;
  logic [PTR_W-1:0]         rptr_q;
  logic [CNT_W-1:0]         count_q;
  logic [CNT_W:0]           reserved;
  logic                     do_push;
  logic                     do_pop;

  ////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////

  assign buf_io.empty    = (count_q == '0);
  assign buf_io.pop_data = mem_q[rptr_q];

  // Words stored plus the word still on its way from memory
  assign reserved    = {1'b0, count_q} + {{CNT_W{1'b0}}, buf_io.outstanding};
  assign buf_io.full = (reserved >= (CNT_W + 1)'(`CORE_BUF_DEPTH));

  // Fetch never pushes without room, it reserved the slot on request
  assign do_push = buf_io.push_valid;
  assign do_pop  = buf_io.pop && !buf_io.empty;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= buf_io.push_data;
    end
  end

  // Pointers wrap at the last entry, count tracks the fill level
  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == LAST_PTR) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == LAST_PTR) ? '0 : rptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_controller (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  logic                    fetch_en_i,
  input  logic                    irq_i,
  input  logic                    if_busy_i,

  // Towards fetch and the sleep unit
  output logic                    halt_o,
  output logic                    ctrl_busy_o,
  output logic                    wake_o,

  output logic [`CORE_DATA_W-1:0] result_o,
  output logic                    result_valid_o,

  instr_buf_if.consumer           buf_i
);

  core_pkg::ctrl_state_e   state_q;
  core_pkg::ctrl_state_e   state_d;
  core_pkg::opcode_e       opcode;
  logic                    do_pop;
  logic [`CORE_DATA_W-1:0] imm;
  logic [`CORE_DATA_W-1:0] acc_q;
  logic [`CORE_DATA_W-1:0] result_q;
  logic                    result_valid_q;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // One instruction per cycle while running and something is buffered
  assign do_pop     = (state_q == core_pkg::RUN) && !buf_i.empty;
  assign buf_i.pop  = do_pop;

  assign opcode = core_pkg::opcode_e'(buf_i.pop_data[`CORE_OP_MSB:`CORE_OP_LSB]);
  // Immediate is zero-extended into the accumulator width
  assign imm = {{(`CORE_DATA_W - `CORE_IMM_W){1'b0}}, buf_i.pop_data[`CORE_IMM_W-1:0]};

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      core_pkg::RESET: begin
        if (fetch_en_i) begin
          state_d = core_pkg::RUN;
        end
      end
      core_pkg::RUN: begin
        if (do_pop && opcode == core_pkg::OP_WFI) begin
          state_d = core_pkg::WAIT_SLEEP;
        end
      end
      core_pkg::WAIT_SLEEP: begin
        // Let the request in flight land in the buffer first
        if (!if_busy_i) begin
          state_d = core_pkg::SLEEP;
        end
      end
      core_pkg::SLEEP: begin
        if (irq_i) begin
          state_d = core_pkg::RUN;
        end
      end
      default: state_d = core_pkg::RESET;
    endcase
  end

  // Halt fetch as soon as WFI is seen, no new requests until wake
  assign halt_o      = (state_q == core_pkg::WAIT_SLEEP) || (state_q == core_pkg::SLEEP);
  assign ctrl_busy_o = (state_q != core_pkg::SLEEP);
  // Opens the clock gate directly, the registered busy path would be too late
  assign wake_o      = irq_i && (state_q == core_pkg::SLEEP);

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= core_pkg::RESET;
      acc_q          <= '0;
      result_q       <= '0;
      result_valid_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      result_valid_q <= 1'b0;
      if (do_pop) begin
        case (opcode)
          core_pkg::OP_ADDI: acc_q <= acc_q + imm;
          core_pkg::OP_OUT: begin
            result_q       <= acc_q;
            result_valid_q <= 1'b1;
          end
          // NOP does nothing and WFI only moves the state machine
          default: ;
        endcase
      end
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

//--- verilog/core_sleep_unit.sv
`timescale 1ns/1ps
`default_nettype none

module core_sleep_unit (
  // Free-running clock in, gated core clock out
  input  logic clk_i,
  input  logic rst_n,
  output logic clk_o,

  input  logic fetch_enable_i,
  output logic fetch_enable_o,

  // Status of the gated blocks
  input  logic if_busy_i,
  input  logic ctrl_busy_i,
  input  logic wake_i,

  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic fetch_enable_d;
  logic core_busy_q;
  logic core_busy_d;
  logic clock_en;
  logic gate_en;

  ////////////////////////////////////////////////////////////
  // Enable and busy tracking
  ////////////////////////////////////////////////////////////

  // Fetch enable sticks once seen, the core never stops fetching again
  assign fetch_enable_d = fetch_enable_i || fetch_enable_q;

  // Busy unless the controller sleeps and no fetch is pending
  assign core_busy_d = if_busy_i || ctrl_busy_i;

  // These run on clk_i so they still see the core go idle
  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      fetch_enable_q <= fetch_enable_d;
      core_busy_q    <= core_busy_d;
    end
  end

  // Clock runs after the first fetch enable, while busy or while an irq wakes us
  assign clock_en = fetch_enable_q && (wake_i || core_busy_q);

  assign fetch_enable_o = fetch_enable_q;

  // The core counts as asleep while started but gated, in SLEEP and for one cycle after a wake
  assign core_sleep_o = fetch_enable_q && !clock_en;

  ////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////

  // Enable is sampled in the low phase so the gated clock has no glitches
  always_latch begin
    if (!clk_i) begin
      gate_en = clock_en;
    end
  end

  assign clk_o = clk_i & gate_en;

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_top (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     fetch_enable_i,
  input  logic                     irq_i,

  // Instruction port
  output logic                     instr_req_o,
  output logic [`CORE_ADDR_W-1:0]  instr_addr_o,
  input  logic [`CORE_INSTR_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,

  output logic [`CORE_DATA_W-1:0]  result_o,
  output logic                     result_valid_o,
  output logic                     core_sleep_o
);

  logic core_clk;
  logic fetch_en;
  logic if_busy;
  logic ctrl_busy;
  logic wake;
  logic halt;

  instr_buf_if buf_if ();

  ////////////////////////////////////////////////////////////
  // Sleep unit on the free-running clock
  ////////////////////////////////////////////////////////////

  core_sleep_unit sleep_unit_i (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .clk_o          (core_clk),
    .fetch_enable_i (fetch_enable_i),
    .fetch_enable_o (fetch_en),
    .if_busy_i      (if_busy),
    .ctrl_busy_i    (ctrl_busy),
    .wake_i         (wake),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////////////////////////////////////////////
  // Everything below runs on the gated clock
  ////////////////////////////////////////////////////////////

  core_fetch fetch_i (
    .clk_i          (core_clk),
    .rst_n          (rst_n),
    .fetch_en_i     (fetch_en),
    .halt_i         (halt),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (if_busy),
    .buf_o          (buf_if.producer)
  );

  core_prefetch_buffer prefetch_buffer_i (
    .clk_i  (core_clk),
    .rst_n  (rst_n),
    .buf_io (buf_if.store)
  );

  core_controller controller_i (
    .clk_i          (core_clk),
    .rst_n          (rst_n),
    .fetch_en_i     (fetch_en),
    .irq_i          (irq_i),
    .if_busy_i      (if_busy),
    .halt_o         (halt),
    .ctrl_busy_o    (ctrl_busy),
    .wake_o         (wake),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .buf_i          (buf_if.consumer)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n
);

  // Free-running 10 ns clock with its first rising edge at 5 ns
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset stays low for two full cycles and is released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module tb_core_top;

  localparam int          PROG_LEN   = 20;
  localparam int          MAX_EVENTS = 16;
  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] LFSR_SEED  = 32'h26ce;
  // Memory model states
  localparam int          MEM_IDLE   = 0;
  localparam int          MEM_TAKEN  = 1;
  localparam int          MEM_DELAY  = 2;

  logic                     clk;
  logic                     rst_n;
  logic                     fetch_enable_i;
  logic                     irq_i;
  logic                     instr_req_o;
  logic [`CORE_ADDR_W-1:0]  instr_addr_o;
  logic [`CORE_INSTR_W-1:0] instr_rdata_i;
  logic                     instr_rvalid_i;
  logic [`CORE_DATA_W-1:0]  result_o;
  logic                     result_valid_o;
  logic                     core_sleep_o;

  logic [`CORE_INSTR_W-1:0] program_mem [PROG_LEN];
  logic [`CORE_DATA_W-1:0]  exp_result [MAX_EVENTS];
  // Number of results that must be out before each sleep
  int                       sleep_after [MAX_EVENTS];
  int                       n_results;
  int                       n_sleeps;
  int                       result_count;
  int                       error_count;
  int                       timeout_count;
  // Separate streams so the memory model and the irq timing never share a step
  logic [31:0]              mem_lfsr;
  logic [31:0]              irq_lfsr;

  tb_clk_gen clk_gen_i (
    .clk_o (clk),
    .rst_n (rst_n)
  );

  core_top dut_i (
    .clk_i          (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .irq_i          (irq_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////////////////////////////////////////////
  // Program and expected results
  ////////////////////////////////////////////////////////////

  task automatic load_program();
    program_mem[0]  = 16'h4005;  // ADDI 05
    program_mem[1]  = 16'h4003;  // ADDI 03
    program_mem[2]  = 16'h8000;  // OUT
    program_mem[3]  = 16'h40FF;  // ADDI FF
    program_mem[4]  = 16'h8000;  // OUT
    program_mem[5]  = 16'h8000;  // OUT back to back
    program_mem[6]  = 16'hC000;  // WFI
    program_mem[7]  = 16'h6A40;  // ADDI 40 with bits 13:8 to be ignored
    program_mem[8]  = 16'h8000;  // OUT
    program_mem[9]  = 16'h0000;  // NOP
    program_mem[10] = 16'h4080;  // ADDI 80
    program_mem[11] = 16'h407F;  // ADDI 7F
    program_mem[12] = 16'h8000;  // OUT
    program_mem[13] = 16'hC000;  // WFI
    program_mem[14] = 16'hC000;  // WFI straight after a wake
    program_mem[15] = 16'h40C3;  // ADDI C3
    program_mem[16] = 16'h8000;  // OUT
    program_mem[17] = 16'h1234;  // NOP with junk in the low bits
    program_mem[18] = 16'h8000;  // OUT
    program_mem[19] = 16'hC000;  // WFI after which the core stays asleep
  endtask

  // Running sum of immediates, one expected value per OUT
  task automatic build_expected();
    logic [`CORE_DATA_W-1:0] acc;
    int                      a;
    acc       = '0;
    n_results = 0;
    n_sleeps  = 0;
    for (a = 0; a < PROG_LEN; a++) begin
      case (core_pkg::opcode_e'(program_mem[a][15:14]))
        core_pkg::OP_ADDI: acc = acc + {8'h00, program_mem[a][7:0]};
        core_pkg::OP_OUT: begin
          exp_result[n_results] = acc;
          n_results++;
        end
        core_pkg::OP_WFI: begin
          sleep_after[n_sleeps] = n_results;
          n_sleeps++;
        end
        default: ;
      endcase
    end
  endtask

  // Words past the end of the table read as NOP
  function automatic logic [`CORE_INSTR_W-1:0] fetch_word(input logic [`CORE_ADDR_W-1:0] addr);
    if (addr < PROG_LEN) begin
      return program_mem[addr];
    end
    return '0;
  endfunction

  ////////////////////////////////////////////////////////////
  // Random numbers, checks and the end of the run
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    // Taps 32, 22, 2 and 1
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One LFSR step for every bit taken
  task automatic draw_bits(inout logic [31:0] state, input int nbits, output int value);
    int i;
    value = 0;
    for (i = 0; i < nbits; i++) begin
      state = lfsr_next(state);
      value = (value << 1) | int'(state[0]);
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, actual,
               expected);
      error_count++;
    end
  endtask

  task automatic finish_run();
    $display("Results seen: %0d of %0d, failed checks: %0d, timeouts: %0d", result_count,
             n_results, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0t ns: waited %0d cycles for %s", $time, TIMEOUT, what);
    timeout_count++;
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////
  // Waits on the DUT
  ////////////////////////////////////////////////////////////

  // Stops at the next result pulse, or early if the core falls asleep
  task automatic wait_result(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout($sformatf("result %0d", idx));
      end
    end while (!result_valid_o && !core_sleep_o);
    check_value(result_valid_o, 1'b1, $sformatf("result %0d arrives before sleep", idx));
    if (result_valid_o) begin
      check_value(result_o, exp_result[idx], $sformatf("value of result %0d", idx));
    end
  endtask

  task automatic wait_sleep(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      check_value(result_valid_o, 1'b0, $sformatf("no extra result before sleep %0d", idx));
      if (cycles > TIMEOUT) begin
        report_timeout($sformatf("sleep %0d", idx));
      end
    end while (!core_sleep_o);
  endtask

  // The sleep flag may stay up one more cycle while the busy register catches up
  task automatic wake_core();
    int delay;
    int cycles;
    draw_bits(irq_lfsr, 3, delay);
    repeat (delay) @(negedge clk);
    irq_i  = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout("the core to wake up");
      end
    end while (core_sleep_o);
    irq_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////

  // A request counts as taken once instr_req_o drops, then 1 to 3 cycles to the answer
  initial begin : memory_model
    int                      state;
    int                      countdown;
    int                      waited;
    int                      pick;
    logic [`CORE_ADDR_W-1:0] req_addr;
    logic [`CORE_ADDR_W-1:0] exp_addr;
    state     = MEM_IDLE;
    countdown = 0;
    waited    = 0;
    req_addr  = '0;
    exp_addr  = '0;
    forever begin
      @(negedge clk);
      instr_rvalid_i = 1'b0;
      if (state == MEM_IDLE && rst_n && instr_req_o) begin
        // Fetch walks the program in order from address 0, also across sleep
        check_value(instr_addr_o, exp_addr, "instruction request address");
        req_addr = instr_addr_o;
        exp_addr = exp_addr + 1'b1;
        waited   = 0;
        state    = MEM_TAKEN;
      end else if (state == MEM_TAKEN) begin
        if (instr_req_o) begin
          waited++;
          if (waited > TIMEOUT) begin
            report_timeout("the core to take its instruction request");
          end
        end else begin
          draw_bits(mem_lfsr, 2, pick);
          countdown = pick % 3;
          state     = MEM_DELAY;
        end
      end
      if (state == MEM_DELAY) begin
        if (countdown == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = fetch_word(req_addr);
          state          = MEM_IDLE;
        end else begin
          countdown--;
        end
      end
    end
  end

  // Counts every result pulse and watches the quiet core while it sleeps
  always @(negedge clk) begin
    if (rst_n) begin
      if (result_valid_o) begin
        result_count++;
      end
      if (core_sleep_o && !irq_i) begin
        check_value(instr_req_o, 1'b0, "no instruction request while asleep");
        check_value(result_valid_o, 1'b0, "no result pulse while asleep");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_flow
    int cycles;
    int res_idx;
    int s;
    fetch_enable_i = 1'b0;
    irq_i          = 1'b0;
    instr_rdata_i  = '0;
    instr_rvalid_i = 1'b0;
    mem_lfsr       = LFSR_SEED;
    irq_lfsr       = LFSR_SEED;
    result_count   = 0;
    error_count    = 0;
    timeout_count  = 0;
    load_program();
    build_expected();

    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_timeout("reset release");
      end
    end

    // Clock stays gated until fetch enable, so all outputs stay quiet
    for (cycles = 0; cycles < 10; cycles++) begin
      @(negedge clk);
      check_value(instr_req_o, 1'b0, "no request before fetch enable");
      check_value(result_valid_o, 1'b0, "no result before fetch enable");
      check_value(core_sleep_o, 1'b0, "not asleep before fetch enable");
    end

    // A single-cycle pulse is enough because the enable is sticky
    fetch_enable_i = 1'b1;
    @(negedge clk);
    fetch_enable_i = 1'b0;

    res_idx = 0;
    for (s = 0; s < n_sleeps; s++) begin
      while (res_idx < sleep_after[s]) begin
        wait_result(res_idx);
        res_idx++;
      end
      wait_sleep(s);
      if (s < n_sleeps - 1) begin
        wake_core();
      end
    end

    // Nothing may follow the final WFI
    repeat (20) @(negedge clk);
    check_value(core_sleep_o, 1'b1, "core stays asleep after the last WFI");
    check_value(result_count, n_results, "total number of result pulses");
    finish_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/core_pkg.sv
verilog/instr_buf_if.sv
verilog/core_fetch.sv
verilog/core_prefetch_buffer.sv
verilog/core_controller.sv
verilog/core_sleep_unit.sv
verilog/core_top.sv
tests/tb_clk_gen.sv
tests/tb_core_top.sv
